/* hdl/lsu_pkg.sv */
package lsu_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    localparam int unsigned XLEN   = 32;
    localparam int unsigned STRB_W = 4;
    localparam int unsigned EXC_W  = 6;

    // ------------------------------------------------------------
    // Instruction match and mask pairs
    // ------------------------------------------------------------
    localparam logic [31:0] INST_LB       = 32'h0000_0003;
    localparam logic [31:0] INST_LB_MASK  = 32'h0000_707f;
    localparam logic [31:0] INST_LH       = 32'h0000_1003;
    localparam logic [31:0] INST_LH_MASK  = 32'h0000_707f;
    localparam logic [31:0] INST_LW       = 32'h0000_2003;
    localparam logic [31:0] INST_LW_MASK  = 32'h0000_707f;
    localparam logic [31:0] INST_LBU      = 32'h0000_4003;
    localparam logic [31:0] INST_LBU_MASK = 32'h0000_707f;
    localparam logic [31:0] INST_LHU      = 32'h0000_5003;
    localparam logic [31:0] INST_LHU_MASK = 32'h0000_707f;
    localparam logic [31:0] INST_SB       = 32'h0000_0023;
    localparam logic [31:0] INST_SB_MASK  = 32'h0000_707f;
    localparam logic [31:0] INST_SH       = 32'h0000_1023;
    localparam logic [31:0] INST_SH_MASK  = 32'h0000_707f;
    localparam logic [31:0] INST_SW       = 32'h0000_2023;
    localparam logic [31:0] INST_SW_MASK  = 32'h0000_707f;

    // ------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------
    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } op_kind_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    // RISC-V cause code offset by 16
    typedef enum logic [EXC_W-1:0] {
        EXC_NONE             = 6'd0,
        EXC_MISALIGNED_LOAD  = 6'd20,
        EXC_FAULT_LOAD       = 6'd21,
        EXC_MISALIGNED_STORE = 6'd22,
        EXC_FAULT_STORE      = 6'd23
    } exc_e;

    // ------------------------------------------------------------
    // Bundles
    // ------------------------------------------------------------
    typedef struct packed {
        logic            valid;
        logic [31:0]     instr;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
    } lsu_op_t;

    typedef struct packed {
        logic              rd;
        logic [STRB_W-1:0] wr;
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   data;
    } mem_req_t;

    typedef struct packed {
        logic            ack;
        logic            error;
        logic [XLEN-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic            is_load;
        size_e           size;
        logic            sgn;
    } resp_ctx_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] value;
        exc_e            exc;
    } wb_t;

endpackage

/* hdl/lsu_issue.sv */
module lsu_issue (
    input  logic               clk_i,
    input  logic               rst_n,
    input  lsu_pkg::lsu_op_t   op_i,
    input  logic               mem_accept_i,
    input  logic               delay_i,
    input  logic               squash_i,
    output lsu_pkg::mem_req_t  mem_req_o,
    output lsu_pkg::resp_ctx_t ctx_o,
    output logic               misaligned_o,
    output logic               stall_o
);
    import lsu_pkg::*;

    logic is_lb, is_lh, is_lw, is_lbu, is_lhu;
    logic is_sb, is_sh, is_sw;
    logic load_w, store_w, signed_w, rd_w, misaligned_w;
    op_kind_e          kind_w;
    size_e             size_w;
    logic [XLEN-1:0]   imm_w;
    logic [XLEN-1:0]   addr_w;
    logic [XLEN-1:0]   data_w;
    logic [STRB_W-1:0] wr_w;

    // E1 stage
    logic              rd_q;
    logic [STRB_W-1:0] wr_q;
    logic              misaligned_q;
    logic [XLEN-1:0]   addr_q;
    logic [XLEN-1:0]   data_q;
    resp_ctx_t         ctx_q;

    logic gate_w, load_en_w, clear_w;

    function automatic logic op_match(
        input logic [31:0] instr,
        input logic [31:0] mask,
        input logic [31:0] inst
    );
        return (instr & mask) == inst;
    endfunction

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------
    assign is_lb  = op_match(op_i.instr, INST_LB_MASK, INST_LB);
    assign is_lh  = op_match(op_i.instr, INST_LH_MASK, INST_LH);
    assign is_lw  = op_match(op_i.instr, INST_LW_MASK, INST_LW);
    assign is_lbu = op_match(op_i.instr, INST_LBU_MASK, INST_LBU);
    assign is_lhu = op_match(op_i.instr, INST_LHU_MASK, INST_LHU);
    assign is_sb  = op_match(op_i.instr, INST_SB_MASK, INST_SB);
    assign is_sh  = op_match(op_i.instr, INST_SH_MASK, INST_SH);
    assign is_sw  = op_match(op_i.instr, INST_SW_MASK, INST_SW);

    always_comb
    begin
        load_w   = op_i.valid && (is_lb || is_lh || is_lw || is_lbu || is_lhu);
        store_w  = op_i.valid && (is_sb || is_sh || is_sw);
        kind_w   = load_w ? OP_LOAD : OP_STORE;
        signed_w = is_lb || is_lh || is_lw;

        if (is_lb || is_lbu || is_sb)
            size_w = SIZE_BYTE;
        else if (is_lh || is_lhu || is_sh)
            size_w = SIZE_HALF;
        else
            size_w = SIZE_WORD;

        // I-immediate for loads, S-immediate for stores
        if (kind_w == OP_LOAD)
            imm_w = {{20{op_i.instr[31]}}, op_i.instr[31:20]};
        else
            imm_w = {{20{op_i.instr[31]}}, op_i.instr[31:25], op_i.instr[11:7]};
        addr_w = op_i.rs1 + imm_w;

        case (size_w)
            SIZE_WORD: misaligned_w = (addr_w[1:0] != 2'b00);
            SIZE_HALF: misaligned_w = addr_w[0];
            default:   misaligned_w = 1'b0;
        endcase
        misaligned_w = misaligned_w && (load_w || store_w);
        rd_w         = load_w && !misaligned_w;

        // Store lanes and byte mask
        case (size_w)
            SIZE_BYTE:
            begin
                data_w = {24'b0, op_i.rs2[7:0]} << {addr_w[1:0], 3'b000};
                wr_w   = 4'b0001 << addr_w[1:0];
            end
            SIZE_HALF:
            begin
                data_w = {16'b0, op_i.rs2[15:0]} << {addr_w[1:0], 3'b000};
                wr_w   = 4'b0011 << addr_w[1:0];
            end
            default:
            begin
                data_w = op_i.rs2;
                wr_w   = 4'b1111;
            end
        endcase
        if (!store_w || misaligned_w)
            wr_w = '0;
    end

    // ------------------------------------------------------------
    // E1 request register
    // ------------------------------------------------------------
    // A misaligned E1 leaves as a dummy response once nothing is outstanding
    assign clear_w   = squash_i || (misaligned_q && !delay_i);
    assign load_en_w = !stall_o;

    always_ff @(posedge clk_i or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_q         <= 1'b0;
            wr_q         <= '0;
            misaligned_q <= 1'b0;
        end
        else if (clear_w)
        begin
            rd_q         <= 1'b0;
            wr_q         <= '0;
            misaligned_q <= 1'b0;
        end
        else if (load_en_w)
        begin
            rd_q         <= rd_w;
            wr_q         <= wr_w;
            misaligned_q <= misaligned_w;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (load_en_w)
        begin
            addr_q        <= addr_w;
            data_q        <= data_w;
            ctx_q.addr    <= addr_w;
            ctx_q.is_load <= (kind_w == OP_LOAD);
            ctx_q.size    <= size_w;
            ctx_q.sgn     <= signed_w;
        end
    end

    // Hold strobes back while the previous access is open or being flushed
    assign gate_w         = delay_i || squash_i;
    assign mem_req_o.rd   = rd_q && !gate_w;
    assign mem_req_o.wr   = wr_q & {STRB_W{!gate_w}};
    assign mem_req_o.addr = {addr_q[XLEN-1:2], 2'b00};
    assign mem_req_o.data = data_q;

    assign ctx_o        = ctx_q;
    assign misaligned_o = misaligned_q;

    assign stall_o = ((mem_req_o.rd || (|mem_req_o.wr)) && !mem_accept_i)
                   || delay_i || misaligned_q;

endmodule

/* hdl/lsu_resp_tracker.sv */
module lsu_resp_tracker (
    input  logic               clk_i,
    input  logic               rst_n,
    input  lsu_pkg::mem_req_t  mem_req_i,
    input  logic               mem_accept_i,
    input  logic               misaligned_i,
    input  lsu_pkg::resp_ctx_t ctx_i,
    input  lsu_pkg::mem_rsp_t  mem_rsp_i,
    output logic               delay_o,
    output logic               squash_o,
    output logic               dummy_o,
    output lsu_pkg::resp_ctx_t ctx_o
);
    import lsu_pkg::*;

    logic      pending_q;
    logic      dummy_q;
    resp_ctx_t ctx_mem_q [2];
    logic      rd_ptr_q;
    logic      wr_ptr_q;
    logic [1:0] count_q;

    logic accept_w, ack_ok_w, ack_err_w, dummy_issue_w;
    logic push_w, pop_w;

    // ------------------------------------------------------------
    // Outstanding access
    // ------------------------------------------------------------
    assign accept_w  = (mem_req_i.rd || (|mem_req_i.wr)) && mem_accept_i;
    assign ack_ok_w  = mem_rsp_i.ack && !mem_rsp_i.error;
    assign ack_err_w = mem_rsp_i.ack && mem_rsp_i.error;

    always_ff @(posedge clk_i or negedge rst_n)
    begin
        if (!rst_n)
            pending_q <= 1'b0;
        else if (accept_w)
            pending_q <= 1'b1;
        else if (mem_rsp_i.ack)
            pending_q <= 1'b0;
    end

    // Late response holds back the next request
    assign delay_o  = pending_q && !ack_ok_w;
    assign squash_o = ack_err_w || dummy_q;

    // Misaligned E1 turns into a local response one cycle later
    assign dummy_issue_w = misaligned_i && !delay_o && !squash_o;

    always_ff @(posedge clk_i or negedge rst_n)
    begin
        if (!rst_n)
            dummy_q <= 1'b0;
        else
            dummy_q <= dummy_issue_w;
    end

    // ------------------------------------------------------------
    // Context queue
    // ------------------------------------------------------------
    assign push_w = (accept_w || dummy_issue_w) && (count_q != 2'd2);
    assign pop_w  = (mem_rsp_i.ack || dummy_q) && (count_q != 2'd0);

    always_ff @(posedge clk_i or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end
        else
        begin
            if (push_w)
                wr_ptr_q <= !wr_ptr_q;
            if (pop_w)
                rd_ptr_q <= !rd_ptr_q;
            if (push_w && !pop_w)
                count_q <= count_q + 2'd1;
            else if (pop_w && !push_w)
                count_q <= count_q - 2'd1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (push_w)
            ctx_mem_q[wr_ptr_q] <= ctx_i;
    end

    assign ctx_o   = ctx_mem_q[rd_ptr_q];
    assign dummy_o = dummy_q;

endmodule

/* hdl/lsu_writeback.sv */
module lsu_writeback (
    input  lsu_pkg::mem_rsp_t  mem_rsp_i,
    input  lsu_pkg::resp_ctx_t ctx_i,
    input  logic               dummy_i,
    output lsu_pkg::wb_t       wb_o
);
    import lsu_pkg::*;

    logic            fault_w;
    logic [7:0]      byte_w;
    logic [15:0]     half_w;
    wb_t             wb_r;

    assign fault_w = (mem_rsp_i.ack && mem_rsp_i.error) || dummy_i;

    // ------------------------------------------------------------
    // Lane select
    // ------------------------------------------------------------
    always_comb
    begin
        case (ctx_i.addr[1:0])
            2'd3:    byte_w = mem_rsp_i.rdata[31:24];
            2'd2:    byte_w = mem_rsp_i.rdata[23:16];
            2'd1:    byte_w = mem_rsp_i.rdata[15:8];
            default: byte_w = mem_rsp_i.rdata[7:0];
        endcase

        if (ctx_i.addr[1])
            half_w = mem_rsp_i.rdata[31:16];
        else
            half_w = mem_rsp_i.rdata[15:0];
    end

    // ------------------------------------------------------------
    // Result and exception
    // ------------------------------------------------------------
    always_comb
    begin
        wb_r       = '0;
        wb_r.valid = mem_rsp_i.ack || dummy_i;
        wb_r.exc   = EXC_NONE;

        if (fault_w)
        begin
            // Faulting address goes out as the value
            wb_r.value = ctx_i.addr;
            if (dummy_i)
                wb_r.exc = ctx_i.is_load ? EXC_MISALIGNED_LOAD : EXC_MISALIGNED_STORE;
            else
                wb_r.exc = ctx_i.is_load ? EXC_FAULT_LOAD : EXC_FAULT_STORE;
        end
        else if (mem_rsp_i.ack && ctx_i.is_load)
        begin
            case (ctx_i.size)
                SIZE_BYTE:
                    wb_r.value = {{24{ctx_i.sgn && byte_w[7]}}, byte_w};
                SIZE_HALF:
                    wb_r.value = {{16{ctx_i.sgn && half_w[15]}}, half_w};
                default:
                    wb_r.value = mem_rsp_i.rdata;
            endcase
        end
        // Stores complete with a zero value
    end

    assign wb_o = wb_r;

endmodule

/* hdl/lsu_top.sv */
module lsu_top (
    input  logic              clk_i,
    input  logic              rst_n,
    input  lsu_pkg::lsu_op_t  op_i,
    output lsu_pkg::mem_req_t mem_req_o,
    input  logic              mem_accept_i,
    input  lsu_pkg::mem_rsp_t mem_rsp_i,
    output lsu_pkg::wb_t      wb_o,
    output logic              stall_o
);
    import lsu_pkg::*;

    logic      delay_w;
    logic      squash_w;
    logic      dummy_w;
    logic      misaligned_w;
    resp_ctx_t issue_ctx_w;
    resp_ctx_t head_ctx_w;

    // ------------------------------------------------------------
    // Request side
    // ------------------------------------------------------------
    lsu_issue i_lsu_issue (
        .clk_i        (clk_i),
        .rst_n        (rst_n),
        .op_i         (op_i),
        .mem_accept_i (mem_accept_i),
        .delay_i      (delay_w),
        .squash_i     (squash_w),
        .mem_req_o    (mem_req_o),
        .ctx_o        (issue_ctx_w),
        .misaligned_o (misaligned_w),
        .stall_o      (stall_o)
    );

    // ------------------------------------------------------------
    // Response side
    // ------------------------------------------------------------
    lsu_resp_tracker i_lsu_resp_tracker (
        .clk_i        (clk_i),
        .rst_n        (rst_n),
        .mem_req_i    (mem_req_o),
        .mem_accept_i (mem_accept_i),
        .misaligned_i (misaligned_w),
        .ctx_i        (issue_ctx_w),
        .mem_rsp_i    (mem_rsp_i),
        .delay_o      (delay_w),
        .squash_o     (squash_w),
        .dummy_o      (dummy_w),
        .ctx_o        (head_ctx_w)
    );

    lsu_writeback i_lsu_writeback (
        .mem_rsp_i (mem_rsp_i),
        .ctx_i     (head_ctx_w),
        .dummy_i   (dummy_w),
        .wb_o      (wb_o)
    );

endmodule

/* dv/lsu_mem_model.sv */
module lsu_mem_model (
    input  logic              clk_i,
    input  logic              rst_n,
    input  lsu_pkg::mem_req_t mem_req_i,
    output logic              mem_accept_o,
    output lsu_pkg::mem_rsp_t mem_rsp_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    logic [31:0] mem [64];
    logic [31:0] rnd_q;
    logic        busy_q;
    int          cnt_q;
    logic        err_q;
    logic [31:0] data_q;
    logic        acc_next;
    mem_rsp_t    rsp_next;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Initial contents depend on the whole word index
    function automatic logic [31:0] fill_word(input int idx);
        logic [31:0] w;
        w = idx + 1;
        return (w * 32'h9e37_79b1) ^ {w[15:0], ~w[15:0]};
    endfunction

    // Next outputs are worked out on the rising edge
    always_ff @(posedge clk_i or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 64; i++)
                mem[i] <= fill_word(i);
            rnd_q    <= 32'h60a8;
            busy_q   <= 1'b0;
            cnt_q    <= 0;
            err_q    <= 1'b0;
            data_q   <= '0;
            acc_next <= 1'b0;
            rsp_next <= '0;
        end
        else
        begin
            rnd_q    <= lcg_next(rnd_q);
            acc_next <= |rnd_q[17:16];
            rsp_next <= '0;
            if (busy_q)
            begin
                if (cnt_q == 0)
                begin
                    rsp_next.ack   <= 1'b1;
                    rsp_next.error <= err_q;
                    rsp_next.rdata <= data_q;
                    busy_q         <= 1'b0;
                end
                else
                    cnt_q <= cnt_q - 1;
            end
            if (mem_accept_o && (mem_req_i.rd || (|mem_req_i.wr)))
            begin
                busy_q <= 1'b1;
                cnt_q  <= int'(rnd_q[21:20]);
                err_q  <= (mem_req_i.addr[31:8] != 24'd0);
                if (mem_req_i.addr[31:8] != 24'd0)
                    data_q <= '0;
                else
                begin
                    data_q <= mem[mem_req_i.addr[7:2]];
                    for (int b = 0; b < 4; b++)
                        if (mem_req_i.wr[b])
                            mem[mem_req_i.addr[7:2]][8*b +: 8] <= mem_req_i.data[8*b +: 8];
                end
            end
        end
    end

    // Outputs change on the falling edge
    always_ff @(negedge clk_i or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mem_accept_o <= 1'b0;
            mem_rsp_o    <= '0;
        end
        else
        begin
            mem_accept_o <= acc_next;
            mem_rsp_o    <= rsp_next;
        end
    end

endmodule

/* dv/lsu_tb.sv */
module lsu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    localparam int N_OPS       = 226;
    localparam int CYCLE_LIMIT = 60 * N_OPS;

    logic      clk_i = 1'b0;
    logic      rst_n = 1'b0;
    lsu_op_t   op_i;
    mem_req_t  mem_req_o;
    logic      mem_accept_i;
    mem_rsp_t  mem_rsp_i;
    wb_t       wb_o;
    logic      stall_o;

    logic [31:0] shadow [64];
    logic [31:0] rand_state;
    wb_t         exp_q [$];
    mem_req_t    last_req;
    int          req_count;
    int          cyc;
    int          take_cyc;
    int          wb_cyc;
    int          errors;
    int          checks;

    lsu_top i_lsu_top (
        .clk_i        (clk_i),
        .rst_n        (rst_n),
        .op_i         (op_i),
        .mem_req_o    (mem_req_o),
        .mem_accept_i (mem_accept_i),
        .mem_rsp_i    (mem_rsp_i),
        .wb_o         (wb_o),
        .stall_o      (stall_o)
    );

    lsu_mem_model i_mem (
        .clk_i        (clk_i),
        .rst_n        (rst_n),
        .mem_req_i    (mem_req_o),
        .mem_accept_o (mem_accept_i),
        .mem_rsp_o    (mem_rsp_i)
    );

    always #2 clk_i = ~clk_i;

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Same fill as the memory model
    function automatic logic [31:0] fill_word(input int idx);
        logic [31:0] w;
        w = idx + 1;
        return (w * 32'h9e37_79b1) ^ {w[15:0], ~w[15:0]};
    endfunction

    function automatic lsu_op_t load_op(input logic [2:0] f3, input logic [11:0] imm,
                                        input logic [31:0] rs1);
        lsu_op_t op;
        op.valid = 1'b1;
        op.instr = {imm, 5'd1, f3, 5'd2, 7'h03};
        op.rs1   = rs1;
        op.rs2   = 32'h5a5a_5a5a;
        return op;
    endfunction

    function automatic lsu_op_t store_op(input logic [2:0] f3, input logic [11:0] imm,
                                         input logic [31:0] rs1, input logic [31:0] rs2);
        lsu_op_t op;
        op.valid = 1'b1;
        op.instr = {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], 7'h23};
        op.rs1   = rs1;
        op.rs2   = rs2;
        return op;
    endfunction

    function automatic logic [31:0] eff_addr(input lsu_op_t op);
        logic [31:0] imm;
        if (op.instr[6:0] == 7'h23)
            imm = {{20{op.instr[31]}}, op.instr[31:25], op.instr[11:7]};
        else
            imm = {{20{op.instr[31]}}, op.instr[31:20]};
        return op.rs1 + imm;
    endfunction

    // Expected writeback that also keeps the shadow memory in step with stores
    function automatic wb_t ref_lsu(input lsu_op_t op);
        logic [2:0]  f3;
        logic        is_st;
        logic        mis;
        logic [31:0] addr;
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        int          sh;
        wb_t         r;
        f3      = op.instr[14:12];
        is_st   = (op.instr[6:0] == 7'h23);
        addr    = eff_addr(op);
        sh      = int'(addr[1:0]) * 8;
        mis     = (f3[1:0] == 2'd2 && addr[1:0] != 2'd0) || (f3[1:0] == 2'd1 && addr[0]);
        r.valid = 1'b1;
        r.value = '0;
        r.exc   = EXC_NONE;
        if (mis)
        begin
            r.value = addr;
            r.exc   = is_st ? EXC_MISALIGNED_STORE : EXC_MISALIGNED_LOAD;
        end
        else if (addr >= 32'h100)
        begin
            r.value = addr;
            r.exc   = is_st ? EXC_FAULT_STORE : EXC_FAULT_LOAD;
        end
        else
        begin
            word = shadow[addr[7:2]];
            b    = word[sh +: 8];
            h    = addr[1] ? word[31:16] : word[15:0];
            if (is_st)
            begin
                case (f3[1:0])
                    2'd0:    word[sh +: 8] = op.rs2[7:0];
                    2'd1:    word[sh +: 16] = op.rs2[15:0];
                    default: word = op.rs2;
                endcase
                shadow[addr[7:2]] = word;
            end
            else
            begin
                case (f3)
                    3'd0:    r.value = {{24{b[7]}}, b};
                    3'd4:    r.value = {24'd0, b};
                    3'd1:    r.value = {{16{h[15]}}, h};
                    3'd5:    r.value = {16'd0, h};
                    default: r.value = word;
                endcase
            end
        end
        return r;
    endfunction

    function automatic mem_req_t store_req(input lsu_op_t op);
        logic [31:0] addr;
        mem_req_t    r;
        int          sh;
        addr   = eff_addr(op);
        sh     = int'(addr[1:0]) * 8;
        r.rd   = 1'b0;
        r.addr = {addr[31:2], 2'b00};
        r.data = '0;
        case (op.instr[13:12])
            2'd0:
            begin
                r.wr          = 4'b0001 << addr[1:0];
                r.data[sh +: 8] = op.rs2[7:0];
            end
            2'd1:
            begin
                r.wr           = 4'b0011 << addr[1:0];
                r.data[sh +: 16] = op.rs2[15:0];
            end
            default:
            begin
                r.wr   = 4'b1111;
                r.data = op.rs2;
            end
        endcase
        return r;
    endfunction

    task automatic check_wb(input wb_t got, input wb_t exp);
        checks++;
        if (got.value !== exp.value || got.exc !== exp.exc)
        begin
            errors++;
            $display("ERR %0t: writeback value=%h exc=%0d, expected value=%h exc=%0d",
                     $time, got.value, got.exc, exp.value, exp.exc);
        end
    endtask

    task automatic check_req(input mem_req_t got, input mem_req_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t: request wr=%b addr=%h data=%h, expected wr=%b addr=%h data=%h",
                     $time, got.wr, got.addr, got.data, exp.wr, exp.addr, exp.data);
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    task automatic send_op(input lsu_op_t op);
        @(negedge clk_i);
        op_i = op;
        #1;
        while (stall_o)
        begin
            @(negedge clk_i);
            #1;
        end
        take_cyc = cyc;
        exp_q.push_back(ref_lsu(op));
    endtask

    task automatic drain(input int limit);
        int n;
        n = 0;
        @(negedge clk_i);
        op_i = '0;
        while (exp_q.size() != 0 && n < limit)
        begin
            @(negedge clk_i);
            n++;
        end
        if (exp_q.size() != 0)
        begin
            $display("Missing writeback: %0d expected results never arrived", exp_q.size());
            errors++;
            exp_q.delete();
        end
        repeat (2) @(negedge clk_i);
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        $display("test %0d %s: done, %0d new errors", num, name, errors - err_before);
    endtask

    // Monitor for accepted requests and the writeback compare
    always @(negedge clk_i)
    begin
        #1;
        if (rst_n && mem_accept_i && (mem_req_o.rd || (|mem_req_o.wr)))
        begin
            last_req = mem_req_o;
            req_count++;
        end
        if (rst_n && wb_o.valid)
        begin
            wb_cyc = cyc;
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("Unexpected writeback with no operation waiting for it");
            end
            else
                check_wb(wb_o, exp_q.pop_front());
        end
    end

    always @(posedge clk_i)
    begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT)
        begin
            $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    initial
    begin
        lsu_op_t     op;
        logic [2:0]  f3_tab [8];
        logic [31:0] addr;
        logic [4:0]  imm;
        int          e0;
        int          rc;
        int          sel;
        op_i       = '0;
        errors     = 0;
        checks     = 0;
        req_count  = 0;
        rand_state = 32'h60a8;
        f3_tab     = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd0, 3'd1, 3'd2};
        for (int i = 0; i < 64; i++)
            shadow[i] = fill_word(i);
        repeat (4) @(negedge clk_i);
        rst_n = 1'b1;

        // ------------------------------------------------------------
        // Directed tests
        // ------------------------------------------------------------
        e0 = errors;
        op = store_op(3'd2, 12'h010, 32'h10, 32'hdead_beef);
        send_op(op);
        drain(60);
        check_req(last_req, store_req(op));
        send_op(load_op(3'd2, 12'h010, 32'h10));
        drain(60);
        report_test(1, "sw_lw", e0);

        e0 = errors;
        for (int k = 0; k < 4; k++)
        begin
            op = store_op(3'd0, 12'(k), 32'h40, 32'h1234_5680 + 32'(k) * 32'h21);
            send_op(op);
            drain(60);
            check_req(last_req, store_req(op));
        end
        for (int k = 0; k < 2; k++)
        begin
            op = store_op(3'd1, 12'(2 * k), 32'h44, k == 0 ? 32'h0000_8001 : 32'h0000_7ffe);
            send_op(op);
            drain(60);
            check_req(last_req, store_req(op));
        end
        for (int k = 0; k < 4; k++)
        begin
            send_op(load_op(3'd0, 12'(k), 32'h40));
            send_op(load_op(3'd4, 12'(k), 32'h40));
        end
        for (int k = 0; k < 2; k++)
        begin
            send_op(load_op(3'd1, 12'(2 * k), 32'h44));
            send_op(load_op(3'd5, 12'(2 * k), 32'h44));
        end
        drain(600);
        report_test(2, "byte_half", e0);

        e0 = errors;
        for (int k = 0; k < 4; k++)
        begin
            rc = req_count;
            case (k)
                0:       op = load_op(3'd2, 12'h001, 32'h20);
                1:       op = load_op(3'd1, 12'h003, 32'h20);
                2:       op = store_op(3'd2, 12'h002, 32'h20, 32'h1111_2222);
                default: op = store_op(3'd1, 12'h005, 32'h20, 32'h3333_4444);
            endcase
            send_op(op);
            // The misaligned operation sits in E1 for this cycle
            @(negedge clk_i);
            op_i = '0;
            #1;
            if (stall_o !== 1'b1)
            begin
                errors++;
                $display("Stall was low while misaligned operation %0d sat in E1", k);
            end
            drain(60);
            if (req_count != rc)
            begin
                errors++;
                $display("Misaligned operation %0d reached the memory port", k);
            end
            if (wb_cyc != take_cyc + 2)
            begin
                errors++;
                $display("Misaligned operation %0d wrote back %0d cycles after being taken",
                         k, wb_cyc - take_cyc);
            end
        end
        report_test(3, "misaligned", e0);

        e0 = errors;
        send_op(load_op(3'd2, 12'h000, 32'h100));
        drain(60);
        send_op(store_op(3'd2, 12'h7fc, 32'h0a00, 32'hcafe_f00d));
        drain(60);
        report_test(4, "fault", e0);

        // ------------------------------------------------------------
        // Random aligned mix
        // ------------------------------------------------------------
        e0 = errors;
        for (int i = 0; i < 200; i++)
        begin
            rand_state = lcg_next(rand_state);
            sel        = int'(rand_state[18:16]);
            addr       = {24'd0, rand_state[29:24], 2'b00};
            imm        = rand_state[4:0];
            if (f3_tab[sel][1:0] == 2'd0)
                addr[1:0] = rand_state[9:8];
            else if (f3_tab[sel][1:0] == 2'd1)
                addr[1] = rand_state[9];
            if (rand_state[13:11] == 3'd0)
            begin
                @(negedge clk_i);
                op_i = '0;
            end
            rand_state = lcg_next(rand_state);
            if (sel >= 5)
                op = store_op(f3_tab[sel], {7'd0, imm}, addr - {27'd0, imm}, rand_state);
            else
                op = load_op(f3_tab[sel], {7'd0, imm}, addr - {27'd0, imm});
            send_op(op);
        end
        drain(1200);
        report_test(5, "random_mix", e0);

        $display("checks=%0d errors=%0d cycles=%0d", checks, errors, cyc);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* list.f */
hdl/lsu_pkg.sv
hdl/lsu_issue.sv
hdl/lsu_resp_tracker.sv
hdl/lsu_writeback.sv
hdl/lsu_top.sv
dv/lsu_mem_model.sv
dv/lsu_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps --top-module lsu_tb \
    -f list.f -o lsu_sim

./obj_dir/lsu_sim > sim.log 2>&1
cat sim.log

if grep -q "Finished with no errors" sim.log; then
    exit 0
fi
exit 1
